//--- Bender.yml
package:
  name: oflow_track

sources:
  # packages first, then the pe bank, interface, resolver and top
  - files:
      - hdl/oflow_core_pkg.sv
      - hdl/oflow_bus_pkg.sv
      - hdl/oflow_pe.sv
      - hdl/interface_cr_pe.sv
      - hdl/oflow_conflict_resolve.sv
      - hdl/oflow_track_top.sv

  - target: test
    files:
      - test/tb_oflow_track.sv

//--- hdl/interface_cr_pe.sv
// ---------------------------------------------------------------------
// score board access between conflict resolver and pe bank
// read mux by pe_sel, write strobe demux by pe_to_change
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module interface_cr_pe (
  input  logic                                clk,  // assertion sampling only
  // pe side
  input  oflow_core_pkg::score_t              pe_score [oflow_core_pkg::PE_NUM],
  input  oflow_core_pkg::id_t                 pe_id [oflow_core_pkg::PE_NUM],
  output oflow_core_pkg::row_t                pe_row_sel,
  output logic [oflow_core_pkg::PE_NUM-1:0]   pe_write_to_pointer,
  output logic [oflow_core_pkg::PE_NUM-1:0]   pe_write_to_id,
  output logic                                pe_data_pointer,
  output oflow_core_pkg::id_t                 pe_data_id,
  output oflow_core_pkg::row_t                pe_row_to_change,
  // resolver side
  input  oflow_core_pkg::row_t                row_sel,
  input  oflow_core_pkg::pe_t                 pe_sel,
  input  oflow_core_pkg::row_t                row_to_change,
  input  oflow_core_pkg::pe_t                 pe_to_change,
  input  logic                                data_pointer,
  input  logic                                write_to_pointer,
  input  oflow_core_pkg::id_t                 data_id,
  input  logic                                write_to_id,
  output oflow_core_pkg::score_t              score,
  output oflow_core_pkg::id_t                 id
);

  assign score = pe_score[pe_sel];  // read mux
  assign id    = pe_id[pe_sel];

  assign pe_row_sel       = row_sel;  // shared by all pes
  assign pe_row_to_change = row_to_change;
  assign pe_data_pointer  = data_pointer;
  assign pe_data_id       = data_id;

  // strobe demux so only the target pe writes
  always_comb begin
    pe_write_to_pointer               = '0;
    pe_write_to_pointer[pe_to_change] = write_to_pointer;
  end

  always_comb begin
    pe_write_to_id               = '0;
    pe_write_to_id[pe_to_change] = write_to_id;
  end

  // pointer and id of a claim land on the same pe
  always @(posedge clk) begin
    assert (pe_write_to_pointer == pe_write_to_id)
      else $error("pointer and id strobes disagree on the target pe");
  end

endmodule

`default_nettype wire

//--- hdl/oflow_bus_pkg.sv
// ---------------------------------------------------------------------
// packed structs for input object, match beat and score board row
// resolver state encoding
// ---------------------------------------------------------------------
`default_nettype none

package oflow_bus_pkg;

  // one detected object from the host
  typedef struct packed {
    oflow_core_pkg::coord_t x;
    oflow_core_pkg::coord_t y;
    logic                   last;  // final object of the frame
  } obj_in_t;

  // one result beat per row
  typedef struct packed {
    oflow_core_pkg::row_t row;
    oflow_core_pkg::id_t  id;
    logic                 is_new;  // fresh id, no old track matched
    logic                 last;    // closes the frame
  } match_t;

  // one score board row inside a pe
  typedef struct packed {
    oflow_core_pkg::score_t score;
    oflow_core_pkg::id_t    id;
    logic                   pointer;  // row claimed this pe
    oflow_core_pkg::coord_t x;
    oflow_core_pkg::coord_t y;
  } sb_entry_t;

  typedef enum logic [2:0] {
    IDLE,    // accepting objects
    SCAN,    // read one pe per cycle
    DECIDE,  // pick and write back
    EMIT,    // hold beat until taken
    UPDATE   // pes adopt claimed rows
  } cr_state_t;

endpackage

`default_nettype wire

//--- hdl/oflow_conflict_resolve.sv
// ---------------------------------------------------------------------
// conflict resolver doing greedy row by row matching over the pe bank
// new id counter, claim write back and match stream
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_conflict_resolve (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   obj_valid,
  output logic                   obj_ready,
  input  logic                   obj_last,
  output logic                   frame_start,
  output oflow_core_pkg::row_t   obj_row,
  output oflow_bus_pkg::match_t  match,
  output logic                   match_valid,
  input  logic                   match_ready,
  output logic                   frame_update,
  output oflow_core_pkg::row_t   row_sel,
  output oflow_core_pkg::pe_t    pe_sel,
  input  oflow_core_pkg::score_t score,
  input  oflow_core_pkg::id_t    id,
  output oflow_core_pkg::row_t   row_to_change,
  output oflow_core_pkg::pe_t    pe_to_change,
  output logic                   data_pointer,
  output oflow_core_pkg::id_t    data_id,
  output logic                   write_to_pointer,
  output logic                   write_to_id
);

  localparam oflow_core_pkg::pe_t PE_LAST = oflow_core_pkg::pe_t'(oflow_core_pkg::PE_NUM - 1);

  oflow_bus_pkg::cr_state_t state;

  oflow_core_pkg::row_t                last_row;  // row with last flag
  oflow_core_pkg::pe_t                 pe_cnt;    // scan position
  logic [oflow_core_pkg::PE_NUM-1:0]   claimed;   // pes taken this frame
  oflow_core_pkg::id_t                 new_id;
  logic                                best_found;
  oflow_core_pkg::score_t              best_score;
  oflow_core_pkg::pe_t                 best_pe;
  oflow_core_pkg::id_t                 best_id;
  logic                                free_found;
  oflow_core_pkg::pe_t                 free_pe;

  logic accept;     // input beat transfers
  logic take_best;  // scanned pe beats current best
  logic take_free;  // first unclaimed empty pe
  logic claim;

  // ---------------------------------------------------------------------
  // handshakes and scan compare
  // ---------------------------------------------------------------------
  assign obj_ready    = (state == oflow_bus_pkg::IDLE);
  assign accept       = obj_valid && obj_ready;
  assign frame_start  = accept && (obj_row == '0);  // first object of frame
  assign match_valid  = (state == oflow_bus_pkg::EMIT);
  assign frame_update = (state == oflow_bus_pkg::UPDATE);

  assign take_best = !claimed[pe_cnt] && (score <= oflow_core_pkg::SCORE_THR)
                     && (!best_found || score < best_score);  // strict compare keeps lower index
  assign take_free = !claimed[pe_cnt] && (score == oflow_core_pkg::SCORE_EMPTY) && !free_found;

  assign row_sel = obj_row;  // walk reuses row counter
  assign pe_sel  = pe_cnt;

  // write back during decide only
  assign claim            = (state == oflow_bus_pkg::DECIDE) && (best_found || free_found);
  assign row_to_change    = obj_row;
  assign pe_to_change     = best_found ? best_pe : free_pe;
  assign data_pointer     = 1'b1;
  assign data_id          = best_found ? best_id : new_id;
  assign write_to_pointer = claim;
  assign write_to_id      = claim;

  // ---------------------------------------------------------------------
  // fsm and control
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= oflow_bus_pkg::IDLE;
      obj_row    <= '0;
      pe_cnt     <= '0;
      claimed    <= '0;
      new_id     <= '0;
      best_found <= 1'b0;
      free_found <= 1'b0;
    end else begin
      case (state)
        oflow_bus_pkg::IDLE: begin
          if (accept) begin
            obj_row <= obj_last ? '0 : obj_row + 1'b1;  // restart at row 0 for the walk
            if (obj_last) state <= oflow_bus_pkg::SCAN;
          end
        end
        oflow_bus_pkg::SCAN: begin
          pe_cnt <= pe_cnt + 1'b1;  // wraps to 0 for next row
          if (take_best) best_found <= 1'b1;
          if (take_free) free_found <= 1'b1;
          if (pe_cnt == PE_LAST) state <= oflow_bus_pkg::DECIDE;
        end
        oflow_bus_pkg::DECIDE: begin
          best_found <= 1'b0;
          free_found <= 1'b0;
          if (claim) claimed[pe_to_change] <= 1'b1;
          if (!best_found) new_id <= new_id + 1'b1;  // wraps
          state <= oflow_bus_pkg::EMIT;
        end
        oflow_bus_pkg::EMIT: begin
          if (match_ready) begin  // stall otherwise
            if (match.last) begin
              state <= oflow_bus_pkg::UPDATE;
            end else begin
              obj_row <= obj_row + 1'b1;
              state   <= oflow_bus_pkg::SCAN;
            end
          end
        end
        oflow_bus_pkg::UPDATE: begin
          claimed <= '0;
          obj_row <= '0;
          state   <= oflow_bus_pkg::IDLE;
        end
        default: state <= oflow_bus_pkg::IDLE;
      endcase
    end
  end

  // payload of scan results and match beat
  always_ff @(posedge clk) begin
    if (accept && obj_last) last_row <= obj_row;
    if (state == oflow_bus_pkg::SCAN && take_best) begin
      best_score <= score;
      best_pe    <= pe_cnt;
      best_id    <= id;
    end
    if (state == oflow_bus_pkg::SCAN && take_free) free_pe <= pe_cnt;
    if (state == oflow_bus_pkg::DECIDE) begin
      match.row    <= obj_row;
      match.id     <= data_id;
      match.is_new <= !best_found;
      match.last   <= (obj_row == last_row);
    end
  end

  a_match_stable: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid && !match_ready |=> match_valid && $stable(match))
    else $error("match beat changed while stalled");

  // a claim only lands on a pe still free in this frame
  a_claim_free_pe: assert property (@(posedge clk) disable iff (!rst_n)
    write_to_pointer |-> !claimed[pe_to_change])
    else $error("claim on a pe already taken this frame");

endmodule

`default_nettype wire

//--- hdl/oflow_core_pkg.sv
// ---------------------------------------------------------------------
// core sizes, field widths and score constants of the tracker
// vector typedefs for coordinates, scores, ids, rows and pe indices
// ---------------------------------------------------------------------
`default_nettype none

package oflow_core_pkg;

  // ---------------------------------------------------------------------
  // sizes
  // ---------------------------------------------------------------------
  localparam int PE_NUM    = 4;   // processing elements
  localparam int PE_LEN    = 2;   // pe index width
  localparam int ROW_NUM   = 8;   // score board depth, max objects per frame
  localparam int ROW_LEN   = 3;   // row index width
  localparam int COORD_LEN = 8;   // one coordinate
  localparam int SCORE_LEN = 9;   // |dx|+|dy| fits with one spare code
  localparam int ID_LEN    = 8;   // track id

  // ---------------------------------------------------------------------
  // vector types
  // ---------------------------------------------------------------------
  typedef logic [COORD_LEN-1:0] coord_t;
  typedef logic [SCORE_LEN-1:0] score_t;
  typedef logic [ID_LEN-1:0]    id_t;
  typedef logic [ROW_LEN-1:0]   row_t;
  typedef logic [PE_LEN-1:0]    pe_t;

  // largest score still accepted as the same object
  localparam score_t SCORE_THR   = score_t'(32);
  // reported by a pe with no tracked object, max real score is 510
  localparam score_t SCORE_EMPTY = '1;

endpackage

`default_nettype wire

//--- hdl/oflow_pe.sv
// ---------------------------------------------------------------------
// processing element holding one tracked object
// scores every new object as |dx|+|dy| into a private score board
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_pe (
  input  logic                   clk,
  input  logic                   rst_n,
  input  oflow_bus_pkg::obj_in_t obj,
  input  logic                   obj_write,
  input  oflow_core_pkg::row_t   obj_row,
  input  logic                   frame_start,
  input  logic                   frame_update,
  input  oflow_core_pkg::row_t   row_sel,
  input  logic                   write_to_pointer,
  input  logic                   write_to_id,
  input  logic                   data_pointer,
  input  oflow_core_pkg::id_t    data_id,
  input  oflow_core_pkg::row_t   row_to_change,
  output oflow_core_pkg::score_t score,
  output oflow_core_pkg::id_t    id
);

  oflow_bus_pkg::sb_entry_t sb [oflow_core_pkg::ROW_NUM];  // score board

  logic                   trk_valid;  // pe owns a track
  oflow_core_pkg::coord_t trk_x;
  oflow_core_pkg::coord_t trk_y;
  oflow_core_pkg::id_t    trk_id;

  oflow_core_pkg::coord_t dx;
  oflow_core_pkg::coord_t dy;
  oflow_core_pkg::score_t new_score;
  logic                   hit;      // some row points here
  oflow_core_pkg::row_t   hit_row;

  // ---------------------------------------------------------------------
  // distance
  // ---------------------------------------------------------------------
  assign dx = (obj.x > trk_x) ? obj.x - trk_x : trk_x - obj.x;  // |dx|
  assign dy = (obj.y > trk_y) ? obj.y - trk_y : trk_y - obj.y;  // |dy|
  assign new_score = trk_valid ? oflow_core_pkg::score_t'(dx) + oflow_core_pkg::score_t'(dy)
                               : oflow_core_pkg::SCORE_EMPTY;   // free pe

  // lowest row with pointer set, one claim per frame anyway
  always_comb begin
    hit     = 1'b0;
    hit_row = '0;
    for (int r = oflow_core_pkg::ROW_NUM - 1; r >= 0; r--) begin
      if (sb[r].pointer) begin
        hit     = 1'b1;
        hit_row = oflow_core_pkg::row_t'(r);
      end
    end
  end

  // ---------------------------------------------------------------------
  // score board and tracked payload
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (frame_start) begin
      for (int r = 0; r < oflow_core_pkg::ROW_NUM; r++) begin
        sb[r].pointer <= 1'b0;  // new frame, no claims
      end
    end
    if (obj_write) begin
      sb[obj_row].score <= new_score;
      sb[obj_row].id    <= trk_id;   // read back by resolver
      sb[obj_row].x     <= obj.x;
      sb[obj_row].y     <= obj.y;
    end
    if (write_to_pointer) begin
      sb[row_to_change].pointer <= data_pointer;
    end
    if (write_to_id) begin
      sb[row_to_change].id <= data_id;  // matched or fresh id
    end
    if (frame_update && hit) begin
      trk_x  <= sb[hit_row].x;  // adopt claiming object
      trk_y  <= sb[hit_row].y;
      trk_id <= sb[hit_row].id;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trk_valid <= 1'b0;
    end else if (frame_update) begin
      trk_valid <= hit;  // unclaimed pe drops its track
    end
  end

  assign score = sb[row_sel].score;  // read port toward resolver
  assign id    = sb[row_sel].id;

  // resolver only pulses update after the whole frame was taken in
  a_no_write_on_update: assert property (@(posedge clk) disable iff (!rst_n)
    !(obj_write && frame_update))
    else $error("object written during frame update");

endmodule

`default_nettype wire

//--- hdl/oflow_track_top.sv
// ---------------------------------------------------------------------
// tracker top, object and match streams
// pe bank, score board interface and conflict resolver
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_track_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  oflow_bus_pkg::obj_in_t obj,
  input  logic                  obj_valid,
  output logic                  obj_ready,
  output oflow_bus_pkg::match_t match,
  output logic                  match_valid,
  input  logic                  match_ready
);

  logic                              obj_write;  // object broadcast strobe
  logic                              frame_start;
  logic                              frame_update;
  oflow_core_pkg::row_t              obj_row;
  // pe side of the interface
  oflow_core_pkg::score_t            pe_score [oflow_core_pkg::PE_NUM];
  oflow_core_pkg::id_t               pe_id [oflow_core_pkg::PE_NUM];
  oflow_core_pkg::row_t              pe_row_sel;
  logic [oflow_core_pkg::PE_NUM-1:0] pe_write_to_pointer;
  logic [oflow_core_pkg::PE_NUM-1:0] pe_write_to_id;
  logic                              pe_data_pointer;
  oflow_core_pkg::id_t               pe_data_id;
  oflow_core_pkg::row_t              pe_row_to_change;
  // resolver side
  oflow_core_pkg::row_t              row_sel;
  oflow_core_pkg::pe_t               pe_sel;
  oflow_core_pkg::score_t            score;
  oflow_core_pkg::id_t               id;
  oflow_core_pkg::row_t              row_to_change;
  oflow_core_pkg::pe_t               pe_to_change;
  logic                              data_pointer;
  oflow_core_pkg::id_t               data_id;
  logic                              write_to_pointer;
  logic                              write_to_id;

  assign obj_write = obj_valid && obj_ready;  // every pe scores each accepted object

  // ---------------------------------------------------------------------
  // pe bank
  // ---------------------------------------------------------------------
  for (genvar g = 0; g < oflow_core_pkg::PE_NUM; g++) begin : g_pe
    oflow_pe pe_i (
      .clk, .rst_n, .obj, .obj_write, .obj_row, .frame_start, .frame_update,
      .row_sel          (pe_row_sel),
      .write_to_pointer (pe_write_to_pointer[g]),
      .write_to_id      (pe_write_to_id[g]),
      .data_pointer     (pe_data_pointer),
      .data_id          (pe_data_id),
      .row_to_change    (pe_row_to_change),
      .score            (pe_score[g]),
      .id               (pe_id[g])
    );
  end

  interface_cr_pe if_i (
    .clk, .pe_score, .pe_id, .pe_row_sel, .pe_write_to_pointer, .pe_write_to_id,
    .pe_data_pointer, .pe_data_id, .pe_row_to_change,
    .row_sel, .pe_sel, .row_to_change, .pe_to_change, .data_pointer,
    .write_to_pointer, .data_id, .write_to_id, .score, .id
  );

  oflow_conflict_resolve cr_i (
    .clk, .rst_n, .obj_valid, .obj_ready,
    .obj_last (obj.last),
    .frame_start, .obj_row, .match, .match_valid, .match_ready, .frame_update,
    .row_sel, .pe_sel, .score, .id, .row_to_change, .pe_to_change,
    .data_pointer, .data_id, .write_to_pointer, .write_to_id
  );

endmodule

`default_nettype wire

//--- test/tb_oflow_track.sv
// ----------------------------------------------------------------------
// testbench for the tracker core with frame stimulus and reference model
// concurrent checks on every match beat, watchdog and closing report
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_oflow_track;

  localparam int NUM_FRAMES  = 12;
  localparam int FRAME_CYC   = oflow_core_pkg::ROW_NUM * (oflow_core_pkg::PE_NUM + 3) + 20;
  localparam int WATCHDOG_NS = (16 + 2 * NUM_FRAMES * FRAME_CYC + 200) * 40;  // x2 for stalls

  logic                   clk = 1'b0;
  logic                   rst_n;
  oflow_bus_pkg::obj_in_t obj;
  logic                   obj_valid;
  logic                   obj_ready;
  oflow_bus_pkg::match_t  match;
  logic                   match_valid;
  logic                   match_ready;

  integer seed = 32'hca83;
  integer rnd;                // coordinate draws
  integer gap;                // match_ready draws
  bit     stall_en = 1'b0;
  bit     frame_busy = 1'b0;  // last object in, last beat still out
  int     err_cnt = 0;
  int     err_at_start;
  int     test_num = 0;
  int     test_ok = 0;
  int     test_bad = 0;

  int fx [oflow_core_pkg::ROW_NUM];  // current frame
  int fy [oflow_core_pkg::ROW_NUM];
  int rnd_x [3 * oflow_core_pkg::ROW_NUM];
  int rnd_y [3 * oflow_core_pkg::ROW_NUM];

  // ----------------------------------------------------------------------
  // reference model state
  // ----------------------------------------------------------------------
  bit m_valid [oflow_core_pkg::PE_NUM];
  int m_x [oflow_core_pkg::PE_NUM];
  int m_y [oflow_core_pkg::PE_NUM];
  int m_id [oflow_core_pkg::PE_NUM];
  int m_new_id = 0;
  oflow_bus_pkg::match_t exp_q [$];
  oflow_bus_pkg::match_t exp_beat;   // head of queue
  bit                    exp_pending = 1'b0;

  oflow_track_top dut_i (
    .clk, .rst_n, .obj, .obj_valid, .obj_ready, .match, .match_valid, .match_ready
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    #2;
    if (stall_en) begin
      gap         = $random(seed);
      match_ready = gap[0];  // about half the cycles stalled
    end else begin
      match_ready = 1'b1;
    end
  end

  // pop each transferred beat
  always @(posedge clk) begin
    if (rst_n && obj_valid && obj_ready && obj.last) frame_busy = 1'b1;
    if (rst_n && match_valid && match_ready && exp_pending) begin
      if (match.last) frame_busy = 1'b0;
      void'(exp_q.pop_front());
      refresh_expected();
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  a_beat_expected: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid && match_ready |-> exp_pending)
    else report_problem("match beat arrived while none was expected");
  a_row: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid && match_ready && exp_pending |-> match.row == exp_beat.row)
    else report_mismatch("match.row", $sampled(match.row), $sampled(exp_beat.row));
  a_id: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid && match_ready && exp_pending |-> match.id == exp_beat.id)
    else report_mismatch("match.id", $sampled(match.id), $sampled(exp_beat.id));
  a_is_new: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid && match_ready && exp_pending |-> match.is_new == exp_beat.is_new)
    else report_mismatch("match.is_new", $sampled(match.is_new), $sampled(exp_beat.is_new));
  a_last: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid && match_ready && exp_pending |-> match.last == exp_beat.last)
    else report_mismatch("match.last", $sampled(match.last), $sampled(exp_beat.last));
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    match_valid && !match_ready |=> match_valid && $stable(match))
    else report_problem("match beat changed or dropped while stalled");
  a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
    frame_busy |-> !obj_ready)
    else report_problem("obj_ready went high before the frame was resolved");

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    err_cnt++;
  endtask

  task automatic refresh_expected();
    exp_pending = (exp_q.size() != 0);
    if (exp_pending) exp_beat = exp_q[0];
  endtask

  function automatic int manhattan_distance(input int ax, input int ay, input int bx, input int by);
    int ddx;
    int ddy;
    ddx = (ax > bx) ? ax - bx : bx - ax;
    ddy = (ay > by) ? ay - by : by - ay;
    return ddx + ddy;
  endfunction

  // greedy rule per row, then the pes adopt their claims
  task automatic predict_frame(input int n);
    bit                    claimed [oflow_core_pkg::PE_NUM];
    int                    claim_row [oflow_core_pkg::PE_NUM];
    int                    claim_id [oflow_core_pkg::PE_NUM];
    int                    best;
    int                    best_s;
    int                    free_pe;
    int                    s;
    oflow_bus_pkg::match_t b;
    for (int p = 0; p < oflow_core_pkg::PE_NUM; p++) claimed[p] = 1'b0;
    for (int r = 0; r < n; r++) begin
      best    = -1;
      best_s  = 0;
      free_pe = -1;
      for (int p = 0; p < oflow_core_pkg::PE_NUM; p++) begin
        s = manhattan_distance(fx[r], fy[r], m_x[p], m_y[p]);
        if (!claimed[p] && m_valid[p] && s <= int'(oflow_core_pkg::SCORE_THR)
            && (best < 0 || s < best_s)) begin
          best   = p;  // strict less, lower index keeps ties
          best_s = s;
        end
        if (!claimed[p] && !m_valid[p] && free_pe < 0) free_pe = p;
      end
      b.row  = oflow_core_pkg::row_t'(r);
      b.last = (r == n - 1);
      if (best >= 0) begin
        b.id            = oflow_core_pkg::id_t'(m_id[best]);
        b.is_new        = 1'b0;
        claimed[best]   = 1'b1;
        claim_row[best] = r;
        claim_id[best]  = m_id[best];
      end else begin
        b.id     = oflow_core_pkg::id_t'(m_new_id);
        b.is_new = 1'b1;
        if (free_pe >= 0) begin
          claimed[free_pe]   = 1'b1;
          claim_row[free_pe] = r;
          claim_id[free_pe]  = m_new_id;
        end
        m_new_id = (m_new_id + 1) % (1 << oflow_core_pkg::ID_LEN);  // wraps
      end
      exp_q.push_back(b);
    end
    for (int p = 0; p < oflow_core_pkg::PE_NUM; p++) begin
      m_valid[p] = claimed[p];  // unclaimed pe drops its track
      if (claimed[p]) begin
        m_x[p]  = fx[claim_row[p]];
        m_y[p]  = fy[claim_row[p]];
        m_id[p] = claim_id[p];
      end
    end
    refresh_expected();
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  task automatic send_object(input int i, input bit last);
    obj.x     = oflow_core_pkg::coord_t'(fx[i]);
    obj.y     = oflow_core_pkg::coord_t'(fy[i]);
    obj.last  = last;
    obj_valid = 1'b1;
    while (!obj_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);  // transfer edge
    #2;
    obj_valid = 1'b0;
  endtask

  task automatic run_frame(input int n);
    predict_frame(n);
    for (int i = 0; i < n; i++) send_object(i, i == n - 1);
    while (exp_pending || frame_busy || !obj_ready) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic begin_test();
    test_num++;
    err_at_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_at_start) begin
      test_ok++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      test_bad++;
      $display("test %0d %s: %0d errors", test_num, name, err_cnt - err_at_start);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    obj         = '0;
    obj_valid   = 1'b0;
    match_ready = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    begin_test();
    assert (obj_ready === 1'b1) else report_mismatch("obj_ready", obj_ready, 1);
    assert (match_valid === 1'b0) else report_mismatch("match_valid", match_valid, 0);
    fx = '{10, 30, 110, 160, 210, 240, 0, 0};
    fy = '{10, 30, 110, 160, 210, 20, 0, 0};
    run_frame(6);  // empty bank, ids 0 to 5
    end_test("fresh tracks");

    begin_test();
    run_frame(6);
    end_test("same coordinates");

    begin_test();
    fx = '{20, 19, 112, 160, 15, 0, 0, 0};  // rows 0, 1, 4 all nearest pe 0
    fy = '{18, 19, 108, 160, 15, 0, 0, 0};
    run_frame(5);
    end_test("conflict");

    begin_test();
    fx = '{20, 19, 250, 0, 0, 0, 0, 0};  // far object, no free pe yet
    fy = '{18, 19, 5, 0, 0, 0, 0, 0};
    run_frame(3);
    fx = '{20, 19, 250, 100, 0, 0, 0, 0};  // now claims a freed pe
    fy = '{18, 19, 5, 200, 0, 0, 0, 0};
    run_frame(4);
    run_frame(4);
    end_test("far object");

    begin_test();
    fx = '{20, 250, 100, 0, 0, 0, 0, 0};  // track 1 missing
    fy = '{18, 5, 200, 0, 0, 0, 0, 0};
    run_frame(3);
    fx = '{20, 250, 100, 180, 0, 0, 0, 0};
    fy = '{18, 5, 200, 60, 0, 0, 0, 0};
    run_frame(4);
    run_frame(4);
    end_test("lost track");

    begin_test();
    for (int k = 0; k < 3 * oflow_core_pkg::ROW_NUM; k++) begin
      rnd = $random(seed);
      if (k < oflow_core_pkg::ROW_NUM) begin
        rnd_x[k] = rnd[7:0];
        rnd_y[k] = rnd[15:8];
      end else begin
        rnd_x[k] = (rnd_x[k - oflow_core_pkg::ROW_NUM] + rnd[3:0] - 8) & 8'hff;  // jitter
        rnd_y[k] = (rnd_y[k - oflow_core_pkg::ROW_NUM] + rnd[7:4] - 8) & 8'hff;
      end
    end
    stall_en = 1'b1;
    for (int f = 0; f < 3; f++) begin
      for (int i = 0; i < oflow_core_pkg::ROW_NUM; i++) begin
        fx[i] = rnd_x[f * oflow_core_pkg::ROW_NUM + i];
        fy[i] = rnd_y[f * oflow_core_pkg::ROW_NUM + i];
      end
      run_frame(oflow_core_pkg::ROW_NUM);
    end
    stall_en = 1'b0;
    end_test("random stalls");

    $display("tests %0d, ok %0d, with errors %0d, failed checks %0d",
             test_num, test_ok, test_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error at %0t ns: watchdog expired before all frames resolved", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/oflow_core_pkg.sv
hdl/oflow_bus_pkg.sv
hdl/oflow_pe.sv
hdl/interface_cr_pe.sv
hdl/oflow_conflict_resolve.sv
hdl/oflow_track_top.sv
test/tb_oflow_track.sv
